//--- wbm_arb.f
+incdir+source
source/wbm_arb_pkg.sv
source/wbm_arbiter.sv
source/wb_req_port.sv
source/wb_ram_slave.sv
source/wbm_arb_top.sv
dv/wbm_arb_tb.sv

//--- dv/wbm_arb_tb.sv
`timescale 1ns/1ps

`include "wbm_arb_params.svh"

module wbm_arb_tb
  import wbm_arb_pkg::*;
();

  localparam int N           = `WBA_NUM_MASTERS;
  localparam int RAM_WORDS   = 1 << `WBA_RAM_AW;
  localparam int TABLE_LEN   = 14;
  localparam int RAND_COUNT  = 40;
  localparam int WATCHDOG_NS = (TABLE_LEN + RAND_COUNT) * 40 * 8;
  localparam int MASK_PORT   = 1;

  typedef logic [N-1:0] pmask_t;

  typedef struct packed {
    logic     chk_dat;  // Data is only defined for reads and errors.
    wba_rsp_t rsp;
  } exp_t;

  typedef struct packed {
    logic [7:0]  port;
    logic        we;
    logic [15:0] adr;
    logic [15:0] dat;
    logic [15:0] exp_dat;
    logic        exp_err;
  } vec_t;

  // Port, we, address, write data, expected read data, expected err.
  localparam vec_t VEC_TBL [TABLE_LEN] = '{
    '{8'd0, 1'b1, 16'h0010, 16'ha5a5, 16'h0000, 1'b0},
    '{8'd0, 1'b0, 16'h0010, 16'h0000, 16'ha5a5, 1'b0},
    '{8'd1, 1'b1, 16'h0021, 16'h1234, 16'h0000, 1'b0},
    '{8'd1, 1'b0, 16'h0021, 16'h0000, 16'h1234, 1'b0},
    '{8'd2, 1'b1, 16'h00ff, 16'hbeef, 16'h0000, 1'b0},
    '{8'd2, 1'b0, 16'h00ff, 16'h0000, 16'hbeef, 1'b0},
    '{8'd0, 1'b1, 16'h0000, 16'h0f0f, 16'h0000, 1'b0},
    '{8'd1, 1'b1, 16'h0100, 16'hdead, 16'h0000, 1'b1},  // Would alias word 0.
    '{8'd2, 1'b0, 16'h0100, 16'h0000, 16'h0000, 1'b1},
    '{8'd0, 1'b0, 16'h0000, 16'h0000, 16'h0f0f, 1'b0},
    '{8'd2, 1'b1, 16'hffff, 16'h5555, 16'h0000, 1'b1},
    '{8'd1, 1'b0, 16'h00ff, 16'h0000, 16'hbeef, 1'b0},
    '{8'd0, 1'b0, 16'h8010, 16'h0000, 16'h0000, 1'b1},
    '{8'd1, 1'b0, 16'h0010, 16'h0000, 16'ha5a5, 1'b0}
  };

  logic                  wb_clk_i;
  logic                  wb_rst_i;
  logic     [N-1:0]      req_vld_i;
  wba_req_t [N-1:0]      req_i;
  logic     [N-1:0]      port_mask_i;
  logic     [N-1:0]      rsp_vld_o;
  wba_rsp_t [N-1:0]      rsp_o;

  logic     [15:0]       model_mem [RAM_WORDS];
  logic                  model_known [RAM_WORDS];
  exp_t                  exp_q [N][$];
  int                    order_q [$];
  int                    rsp_cnt [N];
  int                    rsp_total;
  logic     [N-1:0]      stage_vld;
  wba_req_t [N-1:0]      stage_reqs;
  int                    check_cnt;
  int                    check_fails;
  int                    other_errs;
  integer                seed;

  wbm_arb_top dut0 (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .req_vld_i   (req_vld_i),
    .req_i       (req_i),
    .port_mask_i (port_mask_i),
    .rsp_vld_o   (rsp_vld_o),
    .rsp_o       (rsp_o)
  );

  initial wb_clk_i = 1'b0;
  always #4 wb_clk_i = ~wb_clk_i;

  // ========================================
  // Helpers
  // ========================================

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      check_fails++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Word RAM behavior: in range reads and writes, err with zero data above it.
  function automatic exp_t model_access(input wba_req_t r);
    exp_t e;
    e = '0;
    if (r.adr >= RAM_WORDS) begin
      e.rsp.err = 1'b1;
      e.chk_dat = 1'b1;
    end else if (r.we) begin
      model_mem[r.adr]   = r.dat;
      model_known[r.adr] = 1'b1;
    end else begin
      e.rsp.dat = model_mem[r.adr];
      e.chk_dat = 1'b1;
    end
    return e;
  endfunction

  task automatic stage_req(input int port, input wba_req_t r, input exp_t e);
    stage_vld[port]  = 1'b1;
    stage_reqs[port] = r;
    exp_q[port].push_back(e);
  endtask

  task automatic apply_staged();
    @(posedge wb_clk_i);
    req_vld_i <= stage_vld;
    req_i     <= stage_reqs;
    @(posedge wb_clk_i);
    req_vld_i <= '0;
    stage_vld = '0;
  endtask

  task automatic wait_drain(input pmask_t ports, input int limit);
    int   cycles;
    logic busy;
    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      @(posedge wb_clk_i);
      cycles++;
      busy = 1'b0;
      for (int p = 0; p < N; p++) begin
        if (ports[p] && exp_q[p].size() != 0) busy = 1'b1;
      end
      if (busy && cycles > limit) begin
        $display("ERROR: at %0t ns, responses still missing after %0d cycles", $time, limit);
        other_errs++;
        for (int p = 0; p < N; p++) begin
          if (ports[p]) exp_q[p].delete();
        end
        busy = 1'b0;
      end
    end
  endtask

  // Responses are sampled on the falling edge, half a cycle after they change.
  always @(negedge wb_clk_i) begin : rsp_monitor
    exp_t e;
    for (int p = 0; p < N; p++) begin
      if (!wb_rst_i && rsp_vld_o[p] === 1'b1) begin
        rsp_cnt[p]++;
        rsp_total++;
        order_q.push_back(p);
        if (exp_q[p].size() == 0) begin
          $display("ERROR: at %0t ns, port %0d responded with no request outstanding", $time, p);
          other_errs++;
        end else begin
          e = exp_q[p].pop_front();
          check_value(rsp_o[p].err, e.rsp.err, $sformatf("port %0d err flag", p));
          if (e.chk_dat) check_value(rsp_o[p].dat, e.rsp.dat, $sformatf("port %0d read data", p));
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  // ========================================
  // Test sequence
  // ========================================

  initial begin : main
    wba_req_t   req;
    exp_t       e;
    int         issued;
    int         cnt_before;
    integer     rnd;
    logic [7:0] adr8;
    logic       used [RAM_WORDS];
    seed        = 32'h90b2;
    wb_rst_i    = 1'b1;
    req_vld_i   = '0;
    req_i       = '0;
    port_mask_i = '1;
    stage_vld   = '0;
    stage_reqs  = '0;
    for (int a = 0; a < RAM_WORDS; a++) model_known[a] = 1'b0;
    repeat (8) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    repeat (20) @(posedge wb_clk_i);  // Bus must stay quiet with nothing queued.
    check_value(rsp_total, 0, "responses with no requests applied");

    for (int i = 0; i < TABLE_LEN; i++) begin
      req         = '{we: VEC_TBL[i].we, adr: VEC_TBL[i].adr, dat: VEC_TBL[i].dat};
      e.chk_dat   = !VEC_TBL[i].we || VEC_TBL[i].exp_err;
      e.rsp       = '{dat: VEC_TBL[i].exp_dat, err: VEC_TBL[i].exp_err};
      void'(model_access(req));
      stage_req(int'(VEC_TBL[i].port), req, e);
      apply_staged();
      wait_drain(pmask_t'(1 << VEC_TBL[i].port), 40);
    end

    // All ports in one cycle; the highest index must finish first.
    order_q.delete();
    req = '{we: 1'b1, adr: 16'h0030, dat: 16'h3030};
    stage_req(0, req, model_access(req));
    req = '{we: 1'b0, adr: 16'h0021, dat: 16'h0000};
    stage_req(1, req, model_access(req));
    req = '{we: 1'b0, adr: 16'h0010, dat: 16'h0000};
    stage_req(2, req, model_access(req));
    apply_staged();
    wait_drain('1, 60);
    check_value(order_q.size(), N, "responses to concurrent requests");
    for (int k = 0; k < N && k < order_q.size(); k++) begin
      check_value(order_q[k], N - 1 - k, $sformatf("port of concurrent response %0d", k));
    end

    @(posedge wb_clk_i);
    port_mask_i[MASK_PORT] <= 1'b0;
    cnt_before = rsp_cnt[MASK_PORT];
    req = '{we: 1'b0, adr: 16'h0030, dat: 16'h0000};
    stage_req(MASK_PORT, req, model_access(req));
    req = '{we: 1'b1, adr: 16'h0050, dat: 16'h5a5a};
    stage_req(2, req, model_access(req));
    apply_staged();
    wait_drain(pmask_t'(1 << 2), 40);  // Other ports keep running.
    repeat (30) @(posedge wb_clk_i);
    check_value(rsp_cnt[MASK_PORT], cnt_before, "responses from the masked port");
    check_value(exp_q[MASK_PORT].size(), 1, "requests queued at the masked port");
    port_mask_i[MASK_PORT] <= 1'b1;
    wait_drain(pmask_t'(1 << MASK_PORT), 40);

    issued = 0;
    while (issued < RAND_COUNT) begin
      for (int a = 0; a < RAM_WORDS; a++) used[a] = 1'b0;
      for (int s = 0; s < `WBA_REQ_DEPTH; s++) begin
        for (int p = 0; p < N; p++) begin
          rnd = $random(seed);
          if (issued < RAND_COUNT && rnd[1:0] != 2'b00) begin
            adr8 = rnd[9:2];
            while (used[adr8]) adr8 = adr8 + 1'b1;
            used[adr8] = 1'b1;
            req.adr = {8'h00, adr8};
            req.we  = !model_known[adr8] || rnd[10];  // Unwritten words are never read.
            req.dat = rnd[31:16];
            stage_req(p, req, model_access(req));
            issued++;
          end
        end
        apply_staged();
      end
      wait_drain('1, 200);
    end

    repeat (10) @(posedge wb_clk_i);
    $display("Summary: %0d checks, %0d check failures, %0d other errors",
             check_cnt, check_fails, other_errs);
    if (check_fails == 0 && other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- source/wbm_arb_top.sv
`timescale 1ns/1ps

`include "wbm_arb_params.svh"

module wbm_arb_top
  import wbm_arb_pkg::*;
(
  input  logic                            wb_clk_i,
  input  logic                            wb_rst_i,

  input  logic     [`WBA_NUM_MASTERS-1:0] req_vld_i,
  input  wba_req_t [`WBA_NUM_MASTERS-1:0] req_i,
  input  logic     [`WBA_NUM_MASTERS-1:0] port_mask_i,
  output logic     [`WBA_NUM_MASTERS-1:0] rsp_vld_o,
  output wba_rsp_t [`WBA_NUM_MASTERS-1:0] rsp_o
);

  localparam int N = `WBA_NUM_MASTERS;

  // Ports to arbiter.
  logic     [N-1:0] wbm_cyc;
  logic     [N-1:0] wbm_stb;
  wba_req_t [N-1:0] wbm_req;
  logic     [N-1:0] wbm_ack;
  logic     [N-1:0] wbm_err;
  wba_rsp_t         wbm_rsp;

  // Arbiter to slave.
  logic             wbs_cyc;
  logic             wbs_stb;
  wba_req_t         wbs_req;
  logic             wbs_ack;
  wba_rsp_t         wbs_rsp;

  // ========================================
  // Request ports
  // ========================================

  for (genvar i = 0; i < N; i++) begin : g_port
    wb_req_port u_port (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .req_vld_i (req_vld_i[i]),
      .req_i     (req_i[i]),
      .rsp_vld_o (rsp_vld_o[i]),
      .rsp_o     (rsp_o[i]),
      .wbm_cyc_o (wbm_cyc[i]),
      .wbm_stb_o (wbm_stb[i]),
      .wbm_req_o (wbm_req[i]),
      .wbm_ack_i (wbm_ack[i]),
      .wbm_err_i (wbm_err[i]),
      .wbm_rsp_i (wbm_rsp)
    );
  end

  // ========================================
  // Arbiter and RAM
  // ========================================

  wbm_arbiter u_arb (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wbm_cyc_i  (wbm_cyc),
    .wbm_stb_i  (wbm_stb),
    .wbm_mask_i (port_mask_i),
    .wbm_req_i  (wbm_req),
    .wbm_rsp_o  (wbm_rsp),
    .wbm_ack_o  (wbm_ack),
    .wbm_err_o  (wbm_err),
    .wbs_cyc_o  (wbs_cyc),
    .wbs_stb_o  (wbs_stb),
    .wbs_req_o  (wbs_req),
    .wbs_rsp_i  (wbs_rsp),
    .wbs_ack_i  (wbs_ack)
  );

  wb_ram_slave u_ram (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbs_cyc_i (wbs_cyc),
    .wbs_stb_i (wbs_stb),
    .wbs_req_i (wbs_req),
    .wbs_ack_o (wbs_ack),
    .wbs_err_o (),         // Err also travels in the response struct.
    .wbs_rsp_o (wbs_rsp)
  );

endmodule

//--- source/wb_ram_slave.sv
`timescale 1ns/1ps

`include "wbm_arb_params.svh"

module wb_ram_slave
  import wbm_arb_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,

  input  logic     wbs_cyc_i,
  input  logic     wbs_stb_i,
  input  wba_req_t wbs_req_i,
  output logic     wbs_ack_o,
  output logic     wbs_err_o,
  output wba_rsp_t wbs_rsp_o
);

  localparam int unsigned RAM_WORDS = 1 << `WBA_RAM_AW;

  logic [15:0]            mem [RAM_WORDS];
  logic                   access;
  logic                   in_range;
  logic [`WBA_RAM_AW-1:0] word_adr;
  logic                   ack_q;
  logic                   err_q;
  logic [15:0]            dat_q;

  assign access   = wbs_cyc_i && wbs_stb_i;
  assign in_range = (32'(wbs_req_i.adr) < RAM_WORDS);
  assign word_adr = wbs_req_i.adr[`WBA_RAM_AW-1:0];

  // ========================================
  // Handshake
  // ========================================

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access && in_range;   // One cycle after the strobe.
      err_q <= access && !in_range;  // Address past the end of the RAM.
    end
  end

  // ========================================
  // Storage
  // ========================================

  always_ff @(posedge wb_clk_i) begin
    if (access && in_range && wbs_req_i.we) begin
      mem[word_adr] <= wbs_req_i.dat;
    end
  end

  // Writes and errors return zero data.
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      dat_q <= (in_range && !wbs_req_i.we) ? mem[word_adr] : '0;
    end
  end

  assign wbs_ack_o = ack_q;
  assign wbs_err_o = err_q;
  assign wbs_rsp_o = '{dat: dat_q, err: err_q};

  a_one_reply: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    access |=> $onehot({wbs_ack_o, wbs_err_o})
  ) else $error("Strobe not answered by exactly one of ack and err.");

endmodule

//--- source/wb_req_port.sv
`timescale 1ns/1ps

`include "wbm_arb_params.svh"

module wb_req_port
  import wbm_arb_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,

  // External request and response strobes.
  input  logic     req_vld_i,
  input  wba_req_t req_i,
  output logic     rsp_vld_o,
  output wba_rsp_t rsp_o,

  // Wishbone master toward the arbiter.
  output logic     wbm_cyc_o,
  output logic     wbm_stb_o,
  output wba_req_t wbm_req_o,
  input  logic     wbm_ack_i,
  input  logic     wbm_err_i,
  input  wba_rsp_t wbm_rsp_i
);

  localparam int D  = `WBA_REQ_DEPTH;
  localparam int PW = (D > 1) ? $clog2(D) : 1;
  localparam int CW = $clog2(D + 1);

  typedef enum logic {ST_IDLE, ST_ACTIVE} state_t;

  wba_req_t      fifo_mem [D];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          fifo_full;
  logic          fifo_empty;
  logic          push;
  logic          pop;
  logic          done;
  state_t        state_q;
  logic          cyc_q;
  wba_req_t      cur_req_q;
  logic          rsp_vld_q;
  wba_rsp_t      rsp_q;

  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
    ptr_next = (ptr == PW'(D - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign fifo_full  = (count_q == CW'(D));
  assign fifo_empty = (count_q == '0);
  assign push       = req_vld_i && !fifo_full;
  assign pop        = (state_q == ST_IDLE) && !fifo_empty;  // Head leaves as the cycle starts.
  assign done       = wbm_ack_i || wbm_err_i;

  // ========================================
  // Request FIFO
  // ========================================

  always_ff @(posedge wb_clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ========================================
  // Bus cycle FSM
  // ========================================

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= ST_IDLE;
      cyc_q     <= 1'b0;
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= 1'b0;
      case (state_q)
        ST_IDLE: if (pop) begin
          cyc_q   <= 1'b1;
          state_q <= ST_ACTIVE;
        end
        ST_ACTIVE: if (done) begin
          cyc_q     <= 1'b0;  // Dropped on the edge after ack or err.
          rsp_vld_q <= 1'b1;
          state_q   <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (pop) cur_req_q <= fifo_mem[rd_ptr_q];
    if ((state_q == ST_ACTIVE) && done) begin
      rsp_q <= '{dat: wbm_rsp_i.dat, err: wbm_err_i};
    end
  end

  assign wbm_cyc_o = cyc_q;
  assign wbm_stb_o = cyc_q;  // Single transfer per cycle, so stb follows cyc.
  assign wbm_req_o = cur_req_q;
  assign rsp_vld_o = rsp_vld_q;
  assign rsp_o     = rsp_q;

  a_no_overflow: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    req_vld_i |-> !fifo_full
  ) else $error("Request pushed into a full FIFO.");

endmodule

//--- source/wbm_arbiter.sv
`timescale 1ns/1ps

`include "wbm_arb_params.svh"

module wbm_arbiter
  import wbm_arb_pkg::*;
(
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,

  // Master side.
  input  logic     [`WBA_NUM_MASTERS-1:0]    wbm_cyc_i,
  input  logic     [`WBA_NUM_MASTERS-1:0]    wbm_stb_i,
  input  logic     [`WBA_NUM_MASTERS-1:0]    wbm_mask_i,
  input  wba_req_t [`WBA_NUM_MASTERS-1:0]    wbm_req_i,
  output wba_rsp_t                           wbm_rsp_o,
  output logic     [`WBA_NUM_MASTERS-1:0]    wbm_ack_o,
  output logic     [`WBA_NUM_MASTERS-1:0]    wbm_err_o,

  // Slave side.
  output logic                               wbs_cyc_o,
  output logic                               wbs_stb_o,
  output wba_req_t                           wbs_req_o,
  input  wba_rsp_t                           wbs_rsp_i,
  input  logic                               wbs_ack_i
);

  localparam int N     = `WBA_NUM_MASTERS;
  localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

  logic [N-1:0]     pending_q;
  logic             busy_q;
  logic [IDX_W-1:0] active_q;
  logic             cyc_q;
  logic             stb_q;
  logic             done;

  assign done = wbs_ack_i | wbs_rsp_i.err;  // Slave finished the current cycle.

  // ========================================
  // Pending, busy and grant
  // ========================================

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pending_q <= '0;
      busy_q    <= 1'b0;
      active_q  <= '0;
      cyc_q     <= 1'b0;
      stb_q     <= 1'b0;
    end else begin
      cyc_q <= 1'b0;  // Slave strobe lasts one cycle only.
      stb_q <= 1'b0;

      for (int i = 0; i < N; i++) begin
        if (wbm_cyc_i[i] && wbm_stb_i[i] && wbm_mask_i[i]) begin
          pending_q[i] <= 1'b1;
        end
      end

      // The clear wins over the set above because the owner still holds cyc on this edge.
      if (done) begin
        pending_q[active_q] <= 1'b0;
        busy_q              <= 1'b0;
      end

      if (!busy_q) begin
        if (|pending_q) begin
          cyc_q  <= 1'b1;
          stb_q  <= 1'b1;
          busy_q <= 1'b1;
        end
        for (int j = 0; j < N; j++) begin
          if (pending_q[j]) begin
            active_q <= IDX_W'(j);  // Last match wins, so the highest index has priority.
          end
        end
      end
    end
  end

  // ========================================
  // Steering
  // ========================================

  always_comb begin
    for (int i = 0; i < N; i++) begin
      wbm_ack_o[i] = (active_q == IDX_W'(i)) && wbs_ack_i;
      wbm_err_o[i] = (active_q == IDX_W'(i)) && wbs_rsp_i.err;
    end
  end

  assign wbm_rsp_o = wbs_rsp_i;             // Read data goes to every master.
  assign wbs_req_o = wbm_req_i[active_q];   // Owner holds it until ack or err.
  assign wbs_cyc_o = cyc_q;
  assign wbs_stb_o = stb_q;

  // ========================================
  // Checks
  // ========================================

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wbs_ack_i && wbs_rsp_i.err)
  ) else $error("Slave raised ack and err together.");

  // A slave cycle spans the strobe and the answer one clock later.
  a_no_stb_busy: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    wbs_stb_o |-> !$past(wbs_stb_o) && !$past(wbs_stb_o, 2)
  ) else $error("Slave strobe issued while the bus was busy.");

endmodule

//--- source/wbm_arb_pkg.sv
package wbm_arb_pkg;

  // ========================================
  // Bus payloads
  // ========================================

  // One Wishbone request as issued by a port.
  typedef struct packed {
    logic        we;   // High for a write.
    logic [15:0] adr;  // Word address.
    logic [15:0] dat;  // Write data, ignored on reads.
  } wba_req_t;

  // Result of one Wishbone cycle.
  typedef struct packed {
    logic [15:0] dat;  // Read data, zero on error.
    logic        err;  // Cycle ended with an error.
  } wba_rsp_t;

  // Both structs are 16-bit bus words plus control bits,
  // so widths stay fixed whatever the params header says.
  // The address field is the full bus width; the RAM
  // decodes only its own low bits and flags the rest.

endpackage

//--- source/wbm_arb_params.svh
`ifndef WBM_ARB_PARAMS_SVH
`define WBM_ARB_PARAMS_SVH

// ========================================
// Subsystem sizing
// ========================================

// Number of request ports sharing the slave.
`define WBA_NUM_MASTERS 3

// Entries in each port's request FIFO.
`define WBA_REQ_DEPTH 4

// RAM word address width, 8 gives 256 words.
`define WBA_RAM_AW 8

`endif
